/* chbuf_data_pkg.sv */
package chbuf_data_pkg;

    // input word is three chunks of two 12-bit samples
    localparam int DATA_W    = 72;
    localparam int CHUNK_W   = 24;
    localparam int NUM_CHUNK = DATA_W / CHUNK_W;
    localparam int BANK_W    = 32;
    localparam int NUM_BANKS = 3;
    localparam int NYB_PER_CHUNK = CHUNK_W / 4;

    typedef logic [CHUNK_W-1:0]   chunk_t;
    typedef logic [DATA_W-1:0]    in_word_t;
    typedef logic [BANK_W-1:0]    bank_word_t;
    typedef logic [BANK_W/8-1:0]  byte_en_t;

    // entry i (3 bits at 3*i) names the input nybble for output nybble i
    typedef logic [3*NYB_PER_CHUNK-1:0] nyb_order_t;

    // identity order, nybble i stays in place
    localparam nyb_order_t IDENT_ORDER = {3'd5, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0};

    // phase of the input word within a group of four
    typedef enum logic [2:0] {
        PH_IDLE,
        PH_0,
        PH_1,
        PH_2,
        PH_3
    } phase_e;

endpackage

/* chbuf_bus_pkg.sv */
package chbuf_bus_pkg;

    // byte lane within a 32-bit bank word
    localparam int LANE_W     = 2;
    // bank number in the top bits, 0 to 2, 3 is refused
    localparam int BANK_SEL_W = 2;
    // word index inside a bank, sized for the default UADDR_W + LADDR_W
    localparam int WORD_IDX_W = 8;
    localparam int APB_ADDR_W = BANK_SEL_W + WORD_IDX_W + LANE_W;
    localparam int APB_DATA_W = 8;

    // field offsets within the read address
    localparam int WORD_LSB = LANE_W;
    localparam int BANK_LSB = LANE_W + WORD_IDX_W;

    typedef logic [APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [APB_DATA_W-1:0] apb_data_t;
    typedef logic [BANK_SEL_W-1:0] bank_sel_t;

endpackage

/* event_sequencer.sv */
`timescale 1ns/1ps

module event_sequencer #(
    parameter int UADDR_W   = 3,
    parameter int LADDR_W   = 5,
    parameter int RUN_DELAY = 0
) (
    input  logic                                    memclk_i,
    input  logic                                    RESET_LADDR_DELAY,
    input  logic                                    channel_run_i,
    input  logic [UADDR_W-1:0]                      bram_uaddr_i,
    output chbuf_data_pkg::phase_e                  phase_o,
    output logic                                    capture_valid_o,
    output logic [UADDR_W+LADDR_W-1:0]              word_addr_o,
    output chbuf_data_pkg::byte_en_t [2:0]          bank_be_o,
    output logic [UADDR_W-1:0]                      uaddr_o
);
    import chbuf_data_pkg::*;

    logic               run_d;
    logic               run_prev;
    logic               start;
    logic               start_q;
    phase_e             ph_q;
    logic               grp_done;
    // one bit per pending row write of the last completed group
    logic [2:0]         wr_sr;
    logic               row_active;
    logic [LADDR_W-1:0] laddr;
    logic [UADDR_W-1:0] uaddr;

    // run delay, plain flops
    generate
        if (RUN_DELAY == 0) begin : g_nodly
            assign run_d = channel_run_i;
        end else begin : g_dly
            logic [RUN_DELAY-1:0] run_sr;
            always_ff @(posedge memclk_i) begin
                if (RESET_LADDR_DELAY) begin
                    run_sr <= '0;
                end else begin
                    // oldest bit falls off the top
                    run_sr <= RUN_DELAY'({run_sr, channel_run_i});
                end
            end
            assign run_d = run_sr[RUN_DELAY-1];
        end
    endgenerate

    // first delayed-run cycle after a low
    assign start = run_d && !run_prev;

    // start word is always PH_0
    assign phase_o         = start ? PH_0 : (run_d ? ph_q : PH_IDLE);
    assign capture_valid_o = run_d;

    // fourth word of a group seen, whole group can go out
    assign grp_done   = capture_valid_o && (phase_o == PH_3);
    assign row_active = |wr_sr;

    always_ff @(posedge memclk_i) begin
        if (RESET_LADDR_DELAY) begin
            run_prev <= 1'b0;
            start_q  <= 1'b0;
            ph_q     <= PH_IDLE;
            wr_sr    <= '0;
            laddr    <= '0;
            uaddr    <= '0;
        end else begin
            run_prev <= run_d;
            start_q  <= start;
            wr_sr    <= {wr_sr[1:0], grp_done};
            // ring advance, idle when run drops
            case (phase_o)
                PH_0:    ph_q <= PH_1;
                PH_1:    ph_q <= PH_2;
                PH_2:    ph_q <= PH_3;
                PH_3:    ph_q <= PH_0;
                default: ph_q <= PH_IDLE;
            endcase
            if (start) begin
                uaddr <= bram_uaddr_i;
            end
            // laddr cleared one cycle after start, rows step it
            if (start_q) begin
                laddr <= '0;
            end else if (row_active) begin
                laddr <= laddr + 1'b1;
            end
        end
    end

    assign word_addr_o = {uaddr, laddr};
    assign uaddr_o     = uaddr;

    // each row write fills one full word in every bank
    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_be_o[b] = {$bits(byte_en_t){row_active}};
        end
    end

endmodule

/* bank_packer.sv */
`timescale 1ns/1ps

module bank_packer #(
    parameter chbuf_data_pkg::nyb_order_t SAMPLE_ORDER = chbuf_data_pkg::IDENT_ORDER
) (
    input  logic                               memclk_i,
    input  logic                               RESET_LADDR_DELAY,
    input  chbuf_data_pkg::in_word_t           dat_i,
    input  chbuf_data_pkg::phase_e             phase_i,
    input  logic                               capture_valid_i,
    output chbuf_data_pkg::bank_word_t [2:0]   bank_dat_o
);
    import chbuf_data_pkg::*;

    localparam int GRP_W = 4 * DATA_W;

    // remapped copies of the first three words of a group
    in_word_t   hold [3];
    in_word_t   remap_word;
    logic [GRP_W-1:0] grp_stream;
    // row r of a group, three bank words, row 0 at the front
    bank_word_t row_q [3][NUM_BANKS];

    // output nybble i of a chunk takes input nybble SAMPLE_ORDER[i]
    function automatic chunk_t remap_chunk(input chunk_t c);
        chunk_t     r;
        logic [2:0] src;
        r = '0;
        for (int i = 0; i < NYB_PER_CHUNK; i++) begin
            src = SAMPLE_ORDER[3*i +: 3];
            r[4*i +: 4] = c[4*src +: 4];
        end
        return r;
    endfunction

    always_comb begin
        for (int c = 0; c < NUM_CHUNK; c++) begin
            remap_word[CHUNK_W*c +: CHUNK_W] = remap_chunk(dat_i[CHUNK_W*c +: CHUNK_W]);
        end
    end

    // little-endian byte stream of the whole group, current word last
    assign grp_stream = {remap_word, hold[2], hold[1], hold[0]};

    // hold the first three words until the group is known complete
    always_ff @(posedge memclk_i) begin
        if (capture_valid_i) begin
            case (phase_i)
                PH_0:    hold[0] <= remap_word;
                PH_1:    hold[1] <= remap_word;
                PH_2:    hold[2] <= remap_word;
                default: ;
            endcase
        end
    end

    // bank word j of a group lands in bank j mod 3, row j div 3
    // rows then shift forward one per cycle to feed the banks
    always_ff @(posedge memclk_i) begin
        if (RESET_LADDR_DELAY) begin
            for (int r = 0; r < 3; r++) begin
                for (int b = 0; b < NUM_BANKS; b++) begin
                    row_q[r][b] <= '0;
                end
            end
        end else if (capture_valid_i && phase_i == PH_3) begin
            for (int r = 0; r < 3; r++) begin
                for (int b = 0; b < NUM_BANKS; b++) begin
                    row_q[r][b] <= grp_stream[BANK_W*(3*r+b) +: BANK_W];
                end
            end
        end else begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                row_q[0][b] <= row_q[1][b];
                row_q[1][b] <= row_q[2][b];
            end
        end
    end

    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_dat_o[b] = row_q[0][b];
        end
    end

endmodule

/* event_bank.sv */
`timescale 1ns/1ps

module event_bank #(
    parameter int UADDR_W = 3,
    parameter int LADDR_W = 5
) (
    input  logic                          memclk_i,
    input  chbuf_data_pkg::byte_en_t      wr_be_i,
    input  logic [UADDR_W+LADDR_W-1:0]    wr_addr_i,
    input  chbuf_data_pkg::bank_word_t    wr_dat_i,
    input  logic                          rd_en_i,
    input  logic [UADDR_W+LADDR_W-1:0]    rd_addr_i,
    input  logic [1:0]                    rd_lane_i,
    output logic [7:0]                    rd_byte_o
);
    import chbuf_data_pkg::*;

    localparam int DEPTH = 2 ** (UADDR_W + LADDR_W);

    bank_word_t mem [DEPTH];

    // byte-wide write enables
    always_ff @(posedge memclk_i) begin
        for (int i = 0; i < BANK_W / 8; i++) begin
            if (wr_be_i[i]) begin
                mem[wr_addr_i][8*i +: 8] <= wr_dat_i[8*i +: 8];
            end
        end
    end

    // registered byte read, holds when not enabled
    always_ff @(posedge memclk_i) begin
        if (rd_en_i) begin
            rd_byte_o <= mem[rd_addr_i][8*rd_lane_i +: 8];
        end
    end

endmodule

/* apb_read_port.sv */
`timescale 1ns/1ps

module apb_read_port #(
    parameter int UADDR_W = 3,
    parameter int LADDR_W = 5
) (
    input  logic                              memclk_i,
    input  logic                              RESET_LADDR_DELAY,
    input  logic                              psel_i,
    input  logic                              penable_i,
    input  logic                              pwrite_i,
    input  chbuf_bus_pkg::apb_addr_t          paddr_i,
    output chbuf_bus_pkg::apb_data_t          prdata_o,
    output logic                              pready_o,
    output logic                              pslverr_o,
    output logic [2:0]                        bank_rd_en_o,
    output logic [UADDR_W+LADDR_W-1:0]        rd_addr_o,
    output logic [1:0]                        rd_lane_o,
    input  chbuf_bus_pkg::apb_data_t [2:0]    bank_byte_i
);
    import chbuf_bus_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_DONE
    } rd_state_e;

    rd_state_e state;
    bank_sel_t bank_sel;
    bank_sel_t bank_q;
    logic      acc_start;
    logic      acc_err;
    logic      err_q;

    assign bank_sel = paddr_i[BANK_LSB +: BANK_SEL_W];
    // first access cycle of a transfer
    assign acc_start = (state == ST_IDLE) && psel_i && penable_i;
    assign acc_err   = pwrite_i || (bank_sel == 2'd3);

    assign rd_addr_o = paddr_i[WORD_LSB +: UADDR_W + LADDR_W];
    assign rd_lane_o = paddr_i[LANE_W-1:0];

    // one-cycle read pulse to the addressed bank only
    always_comb begin
        bank_rd_en_o = '0;
        if (acc_start && !acc_err) begin
            bank_rd_en_o[bank_sel] = 1'b1;
        end
    end

    // access cycle, bank read cycle, then pready for one cycle
    always_ff @(posedge memclk_i) begin
        if (RESET_LADDR_DELAY) begin
            state     <= ST_IDLE;
            bank_q    <= '0;
            err_q     <= 1'b0;
            pready_o  <= 1'b0;
            pslverr_o <= 1'b0;
            prdata_o  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (acc_start) begin
                        bank_q <= bank_sel;
                        err_q  <= acc_err;
                        state  <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    pready_o  <= 1'b1;
                    pslverr_o <= err_q;
                    prdata_o  <= err_q ? '0 : bank_byte_i[bank_q];
                    state     <= ST_DONE;
                end
                default: begin
                    pready_o  <= 1'b0;
                    pslverr_o <= 1'b0;
                    state     <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* uram_event_chbuffer.sv */
`timescale 1ns/1ps

module uram_event_chbuffer #(
    parameter int UADDR_W   = 3,
    parameter int LADDR_W   = 5,
    parameter int RUN_DELAY = 0,
    parameter chbuf_data_pkg::nyb_order_t SAMPLE_ORDER = chbuf_data_pkg::IDENT_ORDER
) (
    input  logic                          memclk_i,
    input  logic                          RESET_LADDR_DELAY,
    // capture side
    input  logic                          channel_run_i,
    input  logic [UADDR_W-1:0]            bram_uaddr_i,
    output logic [UADDR_W-1:0]            next_bram_uaddr_o,
    input  chbuf_data_pkg::in_word_t      dat_i,
    // cpu read port
    input  logic                          psel_i,
    input  logic                          penable_i,
    input  logic                          pwrite_i,
    input  chbuf_bus_pkg::apb_addr_t      paddr_i,
    output chbuf_bus_pkg::apb_data_t      prdata_o,
    output logic                          pready_o,
    output logic                          pslverr_o
);
    import chbuf_data_pkg::*;
    import chbuf_bus_pkg::*;

    localparam int WADDR_W = UADDR_W + LADDR_W;

    phase_e                 phase;
    logic                   capture_valid;
    logic [WADDR_W-1:0]     word_addr;
    byte_en_t [2:0]         bank_be;
    bank_word_t [2:0]       bank_dat;
    logic [2:0]             bank_rd_en;
    logic [WADDR_W-1:0]     rd_addr;
    logic [1:0]             rd_lane;
    apb_data_t [2:0]        bank_byte;

    event_sequencer #(
        .UADDR_W   (UADDR_W),
        .LADDR_W   (LADDR_W),
        .RUN_DELAY (RUN_DELAY)
    ) u_seq (
        .memclk_i          (memclk_i),
        .RESET_LADDR_DELAY (RESET_LADDR_DELAY),
        .channel_run_i     (channel_run_i),
        .bram_uaddr_i      (bram_uaddr_i),
        .phase_o           (phase),
        .capture_valid_o   (capture_valid),
        .word_addr_o       (word_addr),
        .bank_be_o         (bank_be),
        .uaddr_o           (next_bram_uaddr_o)
    );

    bank_packer #(
        .SAMPLE_ORDER (SAMPLE_ORDER)
    ) u_pack (
        .memclk_i          (memclk_i),
        .RESET_LADDR_DELAY (RESET_LADDR_DELAY),
        .dat_i             (dat_i),
        .phase_i           (phase),
        .capture_valid_i   (capture_valid),
        .bank_dat_o        (bank_dat)
    );

    // banks A, B, C hold consecutive 4-byte slices of the stream
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        event_bank #(
            .UADDR_W (UADDR_W),
            .LADDR_W (LADDR_W)
        ) u_bank (
            .memclk_i  (memclk_i),
            .wr_be_i   (bank_be[b]),
            .wr_addr_i (word_addr),
            .wr_dat_i  (bank_dat[b]),
            .rd_en_i   (bank_rd_en[b]),
            .rd_addr_i (rd_addr),
            .rd_lane_i (rd_lane),
            .rd_byte_o (bank_byte[b])
        );
    end

    apb_read_port #(
        .UADDR_W (UADDR_W),
        .LADDR_W (LADDR_W)
    ) u_apb (
        .memclk_i          (memclk_i),
        .RESET_LADDR_DELAY (RESET_LADDR_DELAY),
        .psel_i            (psel_i),
        .penable_i         (penable_i),
        .pwrite_i          (pwrite_i),
        .paddr_i           (paddr_i),
        .prdata_o          (prdata_o),
        .pready_o          (pready_o),
        .pslverr_o         (pslverr_o),
        .bank_rd_en_o      (bank_rd_en),
        .rd_addr_o         (rd_addr),
        .rd_lane_o         (rd_lane),
        .bank_byte_i       (bank_byte)
    );

endmodule

/* tb_uram_event_chbuffer.sv */
`timescale 1ns/1ps

module tb_uram_event_chbuffer;
    import chbuf_data_pkg::*;
    import chbuf_bus_pkg::*;

    localparam int UADDR_W = 3;
    localparam int LADDR_W = 5;
    localparam int NBUF    = 2 ** UADDR_W;
    localparam int WORDS   = 2 ** (UADDR_W + LADDR_W);
    localparam int GOLD_N  = 64;
    // second build swaps the two 12-bit samples of each chunk
    localparam nyb_order_t SWAP_ORDER = {3'd2, 3'd1, 3'd0, 3'd5, 3'd4, 3'd3};

    logic               memclk;
    logic               rst;
    logic               channel_run;
    logic [UADDR_W-1:0] bram_uaddr;
    in_word_t           dat;
    logic               psel;
    logic               penable;
    logic               pwrite;
    apb_addr_t          paddr;
    logic [UADDR_W-1:0] next_uaddr0;
    logic [UADDR_W-1:0] next_uaddr1;
    apb_data_t          prdata0;
    apb_data_t          prdata1;
    logic               pready0;
    logic               pready1;
    logic               pslverr0;
    logic               pslverr1;

    // golden records, then the byte model of both builds
    in_word_t   gold [GOLD_N];
    logic [7:0] model_id [NUM_BANKS][WORDS][4];
    logic [7:0] model_sw [NUM_BANKS][WORDS][4];
    bit         written [WORDS];
    int         cyc_count = 0;
    int         cyc_limit = 0;

    uram_event_chbuffer #(
        .UADDR_W (UADDR_W),
        .LADDR_W (LADDR_W)
    ) dut0 (
        .memclk_i          (memclk),
        .RESET_LADDR_DELAY (rst),
        .channel_run_i     (channel_run),
        .bram_uaddr_i      (bram_uaddr),
        .next_bram_uaddr_o (next_uaddr0),
        .dat_i             (dat),
        .psel_i            (psel),
        .penable_i         (penable),
        .pwrite_i          (pwrite),
        .paddr_i           (paddr),
        .prdata_o          (prdata0),
        .pready_o          (pready0),
        .pslverr_o         (pslverr0)
    );

    // same stimulus, non-identity nybble order
    uram_event_chbuffer #(
        .UADDR_W      (UADDR_W),
        .LADDR_W      (LADDR_W),
        .SAMPLE_ORDER (SWAP_ORDER)
    ) dut1 (
        .memclk_i          (memclk),
        .RESET_LADDR_DELAY (rst),
        .channel_run_i     (channel_run),
        .bram_uaddr_i      (bram_uaddr),
        .next_bram_uaddr_o (next_uaddr1),
        .dat_i             (dat),
        .psel_i            (psel),
        .penable_i         (penable),
        .pwrite_i          (pwrite),
        .paddr_i           (paddr),
        .prdata_o          (prdata1),
        .pready_o          (pready1),
        .pslverr_o         (pslverr1)
    );

    always #5 memclk = ~memclk;

    task automatic stop_failed();
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_val(input string name, input logic [71:0] got,
                             input logic [71:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
            stop_failed();
        end
    endtask

    // watchdog on total cycles
    always @(posedge memclk) begin
        cyc_count++;
        if (cyc_limit > 0 && cyc_count > cyc_limit) begin
            $display("ERROR: run went past %0d cycles, the DUT stopped answering", cyc_limit);
            stop_failed();
        end
    end

    // output nybble i of a chunk takes input nybble ord[i]
    function automatic in_word_t swap_nybbles(input in_word_t w, input nyb_order_t ord);
        in_word_t r;
        int       src;
        r = '0;
        for (int n = 0; n < DATA_W / 4; n++) begin
            src = (n / 6) * 6 + int'(ord[3 * (n % 6) +: 3]);
            r[4*n +: 4] = w[4*src +: 4];
        end
        return r;
    endfunction

    // one APB transfer, setup then access until pready
    task automatic apb_access(input apb_addr_t addr, input logic wr,
                              output apb_data_t rd0, output apb_data_t rd1,
                              output logic err0, output logic err1);
        int waited;
        @(negedge memclk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        @(negedge memclk);
        penable = 1'b1;
        @(negedge memclk);
        waited = 1;
        while (!pready0) begin
            if (waited >= 8) begin
                $display("ERROR: no pready_o at address 0x%0h after %0d cycles", addr, waited);
                stop_failed();
            end else begin
                @(negedge memclk);
                waited++;
            end
        end
        // two cycles after the first access cycle
        check_val("pready_o latency", 72'(waited), 72'(2));
        check_val("dut1 pready_o", 72'(pready1), 72'(1));
        rd0  = prdata0;
        rd1  = prdata1;
        err0 = pslverr0;
        err1 = pslverr1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        @(negedge memclk);
        // single-cycle pready
        check_val("pready_o after transfer", 72'(pready0), 72'(0));
    endtask

    task automatic read_and_check(input apb_addr_t addr, input logic [7:0] exp_id,
                                  input logic [7:0] exp_sw);
        apb_data_t rd0;
        apb_data_t rd1;
        logic      err0;
        logic      err1;
        apb_access(addr, 1'b0, rd0, rd1, err0, err1);
        check_val($sformatf("prdata_o @0x%0h", addr), 72'(rd0), 72'(exp_id));
        check_val($sformatf("dut1 prdata_o @0x%0h", addr), 72'(rd1), 72'(exp_sw));
        check_val("pslverr_o", 72'(err0), 72'(0));
        check_val("dut1 pslverr_o", 72'(err1), 72'(0));
    endtask

    // drive one run, model only the whole groups
    task automatic run_capture(input int uaddr, input int groups, input int extra,
                               input int file_words, inout int gp);
        in_word_t    w;
        in_word_t    ws;
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        int          kb;
        int          widx;
        for (int i = 0; i < 4 * groups + extra; i++) begin
            if (i < file_words) begin
                w = gold[gp];
                gp++;
            end else begin
                r0 = $urandom;
                r1 = $urandom;
                r2 = $urandom;
                w  = {r2[7:0], r1, r0};
            end
            @(negedge memclk);
            channel_run = 1'b1;
            // only the start word carries the buffer number
            bram_uaddr  = (i == 0) ? UADDR_W'(uaddr) : ~UADDR_W'(uaddr);
            dat         = w;
            if (i < 4 * groups) begin
                ws = swap_nybbles(w, SWAP_ORDER);
                for (int j = 0; j < DATA_W / 8; j++) begin
                    // byte kb of the run stream, little-endian per word
                    kb   = 9 * i + j;
                    widx = (uaddr << LADDR_W) + (kb / 12) % (2 ** LADDR_W);
                    model_id[(kb / 4) % 3][widx][kb % 4] = w[8*j +: 8];
                    model_sw[(kb / 4) % 3][widx][kb % 4] = ws[8*j +: 8];
                    written[widx] = 1'b1;
                end
            end
        end
        @(negedge memclk);
        channel_run = 1'b0;
        dat         = '0;
        // let the last group drain into the banks
        repeat (8) @(negedge memclk);
        check_val("next_bram_uaddr_o", 72'(next_uaddr0), 72'(uaddr));
        check_val("dut1 next_bram_uaddr_o", 72'(next_uaddr1), 72'(uaddr));
    endtask

    // every modeled byte of one buffer
    task automatic check_buffer(input int uaddr);
        int widx;
        for (int l = 0; l < 2 ** LADDR_W; l++) begin
            widx = (uaddr << LADDR_W) + l;
            if (written[widx]) begin
                for (int b = 0; b < NUM_BANKS; b++) begin
                    for (int ln = 0; ln < 4; ln++) begin
                        read_and_check(apb_addr_t'((b << BANK_LSB) | (widx << WORD_LSB) | ln),
                                       model_id[b][widx][ln], model_sw[b][widx][ln]);
                    end
                end
            end
        end
    endtask

    initial begin
        int        gp;
        int        u;
        int        g;
        int        x;
        int        fw;
        int        nc;
        int        est;
        int        hw [NBUF];
        apb_data_t rd0;
        apb_data_t rd1;
        logic      err0;
        logic      err1;
        memclk      = 1'b0;
        rst         = 1'b1;
        channel_run = 1'b0;
        bram_uaddr  = '0;
        dat         = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        void'($urandom(32'ha9a7));
        $readmemh("chbuffer_golden.txt", gold);
        // size the watchdog from the run records
        foreach (hw[i]) hw[i] = 0;
        est = 40;
        gp  = 0;
        while (gp < GOLD_N && gold[gp] != '0) begin
            u  = int'(gold[gp][39:32]);
            g  = int'(gold[gp][31:24]);
            x  = int'(gold[gp][23:16]);
            fw = int'(gold[gp][15:8]);
            nc = int'(gold[gp][7:0]);
            if (3 * g > hw[u]) begin
                hw[u] = 3 * g;
            end
            est += 4 * g + x + 10 + 6 * (12 * hw[u] + nc);
            gp  += 1 + fw + nc;
        end
        foreach (hw[i]) est += 6 * 12 * hw[i];
        cyc_limit = 4 * est + 200;

        repeat (10) @(negedge memclk);
        rst = 1'b0;
        @(negedge memclk);
        check_val("pready_o after reset", 72'(pready0), 72'(0));
        check_val("pslverr_o after reset", 72'(pslverr0), 72'(0));
        check_val("next_bram_uaddr_o after reset", 72'(next_uaddr0), 72'(0));

        gp = 0;
        while (gp < GOLD_N && gold[gp] != '0) begin
            u  = int'(gold[gp][39:32]);
            g  = int'(gold[gp][31:24]);
            x  = int'(gold[gp][23:16]);
            fw = int'(gold[gp][15:8]);
            nc = int'(gold[gp][7:0]);
            gp++;
            run_capture(u, g, x, fw, gp);
            check_buffer(u);
            // listed bytes, address then both expected bytes
            for (int c = 0; c < nc; c++) begin
                read_and_check(apb_addr_t'(gold[gp][27:16]), gold[gp][15:8], gold[gp][7:0]);
                gp++;
            end
        end

        // later runs must not disturb other buffers
        for (int b = 0; b < NBUF; b++) begin
            check_buffer(b);
        end

        // writes are refused
        apb_access(apb_addr_t'(1 << WORD_LSB), 1'b1, rd0, rd1, err0, err1);
        check_val("pslverr_o on write", 72'(err0), 72'(1));
        check_val("prdata_o on write", 72'(rd0), 72'(0));
        // bank 3 does not exist
        apb_access(apb_addr_t'(3 << BANK_LSB), 1'b0, rd0, rd1, err0, err1);
        check_val("pslverr_o on bank 3", 72'(err0), 72'(1));
        check_val("prdata_o on bank 3", 72'(rd0), 72'(0));

        $display("=== PASS ===");
        $finish;
    end

endmodule

/* chbuffer_golden.txt */
// run header: uaddr, groups, trailing words, words from this file, checks (a byte each)
// then the 72-bit input words, filler after them comes from $urandom
// then the checks: APB address (3 digits), identity byte, sample-swap byte
// a zero header ends the list
// run 1: buffer 2, two groups
0202000504
112233445566778899
0123456789ABCDEF01
FEDCBA987654321000
5A5A5A5AA5A5A5A5C3
A1A2A3A4A5A6A7A8A9
1009978
5014456
9001123
10CA97A
// run 2: buffer 5, one group of filler
0501000000
// run 3: buffer 2 again, one group and two trailing words
0201020102
010203040506070809
1000970
10CA97A
0000000000

/* uram_event_chbuffer.f */
chbuf_data_pkg.sv
chbuf_bus_pkg.sv
event_sequencer.sv
bank_packer.sv
event_bank.sv
apb_read_port.sv
uram_event_chbuffer.sv
tb_uram_event_chbuffer.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the event buffer testbench with Verilator.
# Exit status is 0 only when the testbench reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
    --top-module tb_uram_event_chbuffer \
    -f uram_event_chbuffer.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_uram_event_chbuffer)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "=== PASS ==="; then
    exit 0
fi
exit 1
